// File: hw/beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
   input  wire  logic          bus_clk,
   input  wire  logic          rst,
   input  wire  logic          clear,
   input  wire  logic          step,
   output bus_pkg::beat_t      count,
   output logic                last
);

   import bus_pkg::*;

   // clear wins over step so a new transfer always starts at word 0
   always_ff @(posedge bus_clk) begin
      if (rst || clear) begin
         count <= '0;
      end else if (step) begin
         count <= count + 1'b1;
      end
   end

   // final word of the line
   assign last = (count == beat_t'(NUM_BEATS - 1));

endmodule

`default_nettype wire

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
   input  wire  logic                            bus_clk,
   input  wire  logic                            rst,
   input  wire  logic [bus_pkg::NUM_MASTERS-1:0] br,
   input  wire  logic                            bus_ack,
   output logic [bus_pkg::NUM_MASTERS-1:0]       gnt,
   input  wire  logic [bus_pkg::NUM_MASTERS-1:0] m_start,
   input  wire  logic [bus_pkg::NUM_MASTERS-1:0] m_rw,
   input  wire  bus_pkg::line_idx_t              m_a [bus_pkg::NUM_MASTERS],
   input  wire  bus_pkg::word_t                  m_d [bus_pkg::NUM_MASTERS],
   output logic                                  bus_start,
   output logic                                  bus_rw,
   output bus_pkg::line_idx_t                    bus_a,
   output bus_pkg::word_t                        bus_wd
);

   import bus_pkg::*;

   master_idx_t            last_q;
   master_idx_t            pick_idx;
   logic [NUM_MASTERS-1:0] pick;
   int                     cand;

   // search starts just after the last master served
   always_comb begin
      pick     = '0;
      pick_idx = last_q;
      cand     = 0;
      for (int k = 1; k <= NUM_MASTERS; k++) begin
         cand = (int'(last_q) + k) % NUM_MASTERS;
         if (pick == '0 && br[cand]) begin
            pick[cand] = 1'b1;
            pick_idx   = master_idx_t'(cand);
         end
      end
   end

   // grant held until ack, no preemption
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         gnt    <= '0;
         last_q <= master_idx_t'(NUM_MASTERS - 1);
      end else if (gnt != '0) begin
         if (bus_ack) begin
            gnt <= '0;
         end
      end else if (br != '0) begin
         gnt    <= pick;
         last_q <= pick_idx;
      end
   end

   // bus mux, idle bus reads as zero
   always_comb begin
      bus_start = 1'b0;
      bus_rw    = 1'b0;
      bus_a     = '0;
      bus_wd    = '0;
      for (int k = 0; k < NUM_MASTERS; k++) begin
         if (gnt[k]) begin
            bus_start = m_start[k];
            bus_rw    = m_rw[k];
            bus_a     = m_a[k];
            bus_wd    = m_d[k];
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

   // line geometry and bus population
   localparam int NUM_BEATS   = 4;
   localparam int NUM_MASTERS = 2;
   localparam int MEM_LINES   = 256;

   typedef logic [31:0]                 word_t;
   typedef logic [NUM_BEATS*32-1:0]     line_t;
   typedef logic [15:0]                 addr_t;
   // address bits 11:4, low nibble ignored
   typedef logic [7:0]                  line_idx_t;
   typedef logic [1:0]                  beat_t;
   typedef logic [$clog2(NUM_MASTERS)-1:0] master_idx_t;

   // cache side bus master
   typedef enum logic [2:0] {
      PS_IDLE,
      PS_REQ,
      PS_ADDR,
      PS_WBEAT,
      PS_RBEAT,
      PS_DONE
   } port_state_e;

   // memory side bus slave
   typedef enum logic [2:0] {
      MS_IDLE,
      MS_WCOLLECT,
      MS_MWRITE,
      MS_MREAD,
      MS_RSEND
   } mem_state_e;

endpackage

`default_nettype wire

// File: hw/cache_bus_port.sv
`timescale 1ns/1ps
`default_nettype none

module cache_bus_port (
   input  wire  logic               bus_clk,
   input  wire  logic               rst,
   // cache side
   input  wire  logic               en,
   input  wire  logic               wr,
   input  wire  bus_pkg::addr_t     a,
   input  wire  bus_pkg::line_t     write_data,
   output bus_pkg::line_t           read_data,
   output logic                     r,
   // bus side
   output logic                     br,
   input  wire  logic               gnt,
   output logic                     m_start,
   output logic                     m_rw,
   output bus_pkg::line_idx_t       m_a,
   output bus_pkg::word_t           m_d,
   input  wire  bus_pkg::word_t     bus_rd,
   input  wire  logic               bus_rvalid,
   input  wire  logic               bus_ack
);

   import bus_pkg::*;

   port_state_e state_q;
   port_state_e state_d;
   logic        wr_q;
   line_idx_t   idx_q;
   line_t       wline_q;
   line_t       rbuf_q;
   beat_t       count;
   logic        last;
   logic        step;

   beat_counter u_beats (
      .bus_clk (bus_clk),
      .rst     (rst),
      .clear   (state_q == PS_ADDR),
      .step    (step),
      .count   (count),
      .last    (last)
   );

   // write beats go out back to back, read beats only when valid
   assign step = (state_q == PS_WBEAT) || (state_q == PS_RBEAT && bus_rvalid);

   always_comb begin
      state_d = state_q;
      case (state_q)
         PS_IDLE:  if (en) state_d = PS_REQ;
         PS_REQ:   if (gnt) state_d = PS_ADDR;
         PS_ADDR:  state_d = wr_q ? PS_WBEAT : PS_RBEAT;
         PS_WBEAT: if (last) state_d = PS_DONE;
         PS_RBEAT: if (bus_rvalid && last) state_d = PS_DONE;
         PS_DONE:  if (bus_ack) state_d = PS_IDLE;
         default:  state_d = PS_IDLE;
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state_q <= PS_IDLE;
         r       <= 1'b0;
      end else begin
         state_q <= state_d;
         // one cycle after ack
         r       <= (state_q == PS_DONE) && bus_ack;
      end
   end

   // request capture, only taken while idle
   always_ff @(posedge bus_clk) begin
      if (state_q == PS_IDLE && en) begin
         wr_q    <= wr;
         idx_q   <= a[11:4];
         wline_q <= write_data;
      end
   end

   // read beats land in a staging line, exposed only once complete
   always_ff @(posedge bus_clk) begin
      if (state_q == PS_RBEAT && bus_rvalid) begin
         rbuf_q[count*$bits(word_t) +: $bits(word_t)] <= bus_rd;
      end
      if (state_q == PS_DONE && bus_ack && !wr_q) begin
         read_data <= rbuf_q;
      end
   end

   // br stays up through ack and falls with the return to idle
   assign br      = (state_q != PS_IDLE);
   assign m_start = (state_q == PS_ADDR);
   assign m_rw    = wr_q;
   assign m_a     = idx_q;
   assign m_d     = (state_q == PS_WBEAT) ?
                    wline_q[count*$bits(word_t) +: $bits(word_t)] : '0;

endmodule

`default_nettype wire

// File: hw/line_memory.sv
`timescale 1ns/1ps
`default_nettype none

module line_memory (
   input  wire  logic               bus_clk,
   input  wire  logic               mem_en,
   input  wire  logic               mem_wr,
   input  wire  bus_pkg::line_idx_t mem_idx,
   input  wire  bus_pkg::line_t     mem_wdata,
   output bus_pkg::line_t           mem_rdata
);

   import bus_pkg::*;

   line_t mem [MEM_LINES];

   // one access per cycle, read data one cycle after mem_en
   always_ff @(posedge bus_clk) begin
      if (mem_en) begin
         if (mem_wr) begin
            mem[mem_idx] <= mem_wdata;
         end else begin
            mem_rdata <= mem[mem_idx];
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/mem_bus_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bus_port (
   input  wire  logic               bus_clk,
   input  wire  logic               rst,
   // shared bus
   input  wire  logic               bus_start,
   input  wire  logic               bus_rw,
   input  wire  bus_pkg::line_idx_t bus_a,
   input  wire  bus_pkg::word_t     bus_wd,
   output bus_pkg::word_t           bus_rd,
   output logic                     bus_rvalid,
   output logic                     bus_ack,
   // main memory
   output logic                     mem_en,
   output logic                     mem_wr,
   output bus_pkg::line_idx_t       mem_idx,
   output bus_pkg::line_t           mem_wdata,
   input  wire  bus_pkg::line_t     mem_rdata
);

   import bus_pkg::*;

   mem_state_e state_q;
   mem_state_e state_d;
   line_idx_t  idx_q;
   line_t      wline_q;
   beat_t      count;
   logic       last;
   logic       step;

   beat_counter u_beats (
      .bus_clk (bus_clk),
      .rst     (rst),
      .clear   (state_q == MS_IDLE),
      .step    (step),
      .count   (count),
      .last    (last)
   );

   assign step = (state_q == MS_WCOLLECT) || (state_q == MS_RSEND);

   always_comb begin
      state_d = state_q;
      case (state_q)
         MS_IDLE:     if (bus_start) state_d = bus_rw ? MS_WCOLLECT : MS_MREAD;
         MS_WCOLLECT: if (last) state_d = MS_MWRITE;
         MS_MWRITE:   state_d = MS_IDLE;
         // line is out of the array one cycle later
         MS_MREAD:    state_d = MS_RSEND;
         MS_RSEND:    if (last) state_d = MS_IDLE;
         default:     state_d = MS_IDLE;
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state_q <= MS_IDLE;
         bus_ack <= 1'b0;
      end else begin
         state_q <= state_d;
         // ack closes the transaction the cycle after memory or last beat
         bus_ack <= (state_q == MS_MWRITE) || (state_q == MS_RSEND && last);
      end
   end

   always_ff @(posedge bus_clk) begin
      if (state_q == MS_IDLE && bus_start) begin
         idx_q <= bus_a;
      end
      if (state_q == MS_WCOLLECT) begin
         wline_q[count*$bits(word_t) +: $bits(word_t)] <= bus_wd;
      end
   end

   assign mem_en     = (state_q == MS_MWRITE) || (state_q == MS_MREAD);
   assign mem_wr     = (state_q == MS_MWRITE);
   assign mem_idx    = idx_q;
   assign mem_wdata  = wline_q;

   // word 0 first, mem_rdata holds while mem_en is low
   assign bus_rvalid = (state_q == MS_RSEND);
   assign bus_rd     = bus_rvalid ?
                       mem_rdata[count*$bits(word_t) +: $bits(word_t)] : '0;

endmodule

`default_nettype wire

// File: hw/memory_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memory_subsystem (
   input  wire  logic           bus_clk,
   input  wire  logic           rst,
   // instruction cache
   input  wire  logic           ic_en,
   input  wire  logic           ic_wr,
   input  wire  bus_pkg::addr_t ic_a,
   input  wire  bus_pkg::line_t ic_write_data,
   output bus_pkg::line_t       ic_read_data,
   output logic                 ic_r,
   // data cache
   input  wire  logic           dc_en,
   input  wire  logic           dc_wr,
   input  wire  bus_pkg::addr_t dc_a,
   input  wire  bus_pkg::line_t dc_write_data,
   output bus_pkg::line_t       dc_read_data,
   output logic                 dc_r
);

   import bus_pkg::*;

   // arbitration
   logic [NUM_MASTERS-1:0] br;
   logic [NUM_MASTERS-1:0] gnt;

   // master side, one slot per master
   logic [NUM_MASTERS-1:0] m_start;
   logic [NUM_MASTERS-1:0] m_rw;
   line_idx_t              m_a [NUM_MASTERS];
   word_t                  m_d [NUM_MASTERS];

   // the shared bus
   logic                   bus_start;
   logic                   bus_rw;
   line_idx_t              bus_a;
   word_t                  bus_wd;
   word_t                  bus_rd;
   logic                   bus_rvalid;
   logic                   bus_ack;

   // memory port to array
   logic                   mem_en;
   logic                   mem_wr;
   line_idx_t              mem_idx;
   line_t                  mem_wdata;
   line_t                  mem_rdata;

   // master 0
   cache_bus_port u_ic_port (
      .bus_clk    (bus_clk),
      .rst        (rst),
      .en         (ic_en),
      .wr         (ic_wr),
      .a          (ic_a),
      .write_data (ic_write_data),
      .read_data  (ic_read_data),
      .r          (ic_r),
      .br         (br[0]),
      .gnt        (gnt[0]),
      .m_start    (m_start[0]),
      .m_rw       (m_rw[0]),
      .m_a        (m_a[0]),
      .m_d        (m_d[0]),
      .bus_rd     (bus_rd),
      .bus_rvalid (bus_rvalid),
      .bus_ack    (bus_ack)
   );

   // master 1
   cache_bus_port u_dc_port (
      .bus_clk    (bus_clk),
      .rst        (rst),
      .en         (dc_en),
      .wr         (dc_wr),
      .a          (dc_a),
      .write_data (dc_write_data),
      .read_data  (dc_read_data),
      .r          (dc_r),
      .br         (br[1]),
      .gnt        (gnt[1]),
      .m_start    (m_start[1]),
      .m_rw       (m_rw[1]),
      .m_a        (m_a[1]),
      .m_d        (m_d[1]),
      .bus_rd     (bus_rd),
      .bus_rvalid (bus_rvalid),
      .bus_ack    (bus_ack)
   );

   bus_arbiter u_arbiter (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .br        (br),
      .bus_ack   (bus_ack),
      .gnt       (gnt),
      .m_start   (m_start),
      .m_rw      (m_rw),
      .m_a       (m_a),
      .m_d       (m_d),
      .bus_start (bus_start),
      .bus_rw    (bus_rw),
      .bus_a     (bus_a),
      .bus_wd    (bus_wd)
   );

   mem_bus_port u_mem_port (
      .bus_clk    (bus_clk),
      .rst        (rst),
      .bus_start  (bus_start),
      .bus_rw     (bus_rw),
      .bus_a      (bus_a),
      .bus_wd     (bus_wd),
      .bus_rd     (bus_rd),
      .bus_rvalid (bus_rvalid),
      .bus_ack    (bus_ack),
      .mem_en     (mem_en),
      .mem_wr     (mem_wr),
      .mem_idx    (mem_idx),
      .mem_wdata  (mem_wdata),
      .mem_rdata  (mem_rdata)
   );

   line_memory u_memory (
      .bus_clk   (bus_clk),
      .mem_en    (mem_en),
      .mem_wr    (mem_wr),
      .mem_idx   (mem_idx),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

// File: sim.f
hw/bus_pkg.sv
hw/beat_counter.sv
hw/bus_arbiter.sv
hw/cache_bus_port.sv
hw/mem_bus_port.sv
hw/line_memory.sv
hw/memory_subsystem.sv
verif/bus_chk.sv
verif/memory_subsystem_tb.sv

// File: verif/bus_chk.sv
`timescale 1ns/1ps
`default_nettype none

module bus_chk (
   input  wire  logic                            bus_clk,
   input  wire  logic                            rst,
   input  wire  logic [bus_pkg::NUM_MASTERS-1:0] gnt,
   input  wire  logic                            bus_ack,
   input  wire  logic [bus_pkg::NUM_MASTERS-1:0] r
);

   import bus_pkg::*;

   // running count of failed assertions
   int fail_count = 0;

   // at most one bus owner
   a_gnt_onehot: assert property (@(posedge bus_clk) disable iff (rst) $onehot0(gnt))
      else begin
         $error("gnt is neither one-hot nor zero: %b", gnt);
         fail_count++;
      end

   // no preemption before ack
   a_gnt_hold: assert property (@(posedge bus_clk) disable iff (rst)
      (gnt != '0 && !bus_ack) |=> (gnt == $past(gnt)))
      else begin
         $error("gnt changed before bus_ack");
         fail_count++;
      end

   // sync reset clears grant and ready
   a_reset_low: assert property (@(posedge bus_clk) rst |=> (gnt == '0 && r == '0))
      else begin
         $error("gnt or r high right after reset");
         fail_count++;
      end

   for (genvar k = 0; k < NUM_MASTERS; k++) begin : g_r_pulse
      a_r_single: assert property (@(posedge bus_clk) disable iff (rst) r[k] |=> !r[k])
         else begin
            $error("r of master %0d held for more than one cycle", k);
            fail_count++;
         end
   end

endmodule

bind memory_subsystem bus_chk u_bus_chk (
   .bus_clk (bus_clk),
   .rst     (rst),
   .gnt     (gnt),
   .bus_ack (bus_ack),
   .r       ({dc_r, ic_r})
);

`default_nettype wire

// File: verif/mem_vectors.txt
// tid_mask_op_addr_line, line from word 3 down to word 0
// mask bit 0 ic, bit 1 dc; op 0 read, 1 write, 2 write plus a second en while busy
// write and read back on one port
1_1_1_0120_a1a1a1a1_b2b2b2b2_c3c3c3c3_d4d4d4d4
1_1_0_0120_00000000_00000000_00000000_00000000
1_2_1_0340_0badf00d_12345678_9abcdef0_0f1e2d3c
1_2_0_0348_00000000_00000000_00000000_00000000
// dc writes, ic reads
2_2_1_0560_deadbeef_cafef00d_01020304_a5a55a5a
2_1_0_0560_00000000_00000000_00000000_00000000
// both ports in one cycle, dc on the next line
3_3_1_0780_11112222_33334444_55556666_77778888
3_3_0_0780_00000000_00000000_00000000_00000000
3_1_0_0790_00000000_00000000_00000000_00000000
3_2_0_0770_00000000_00000000_00000000_00000000
// address bit 12 and low nibble ignored
4_1_1_0a30_f0f0f0f0_0f0f0f0f_3c3c3c3c_c3c3c3c3
4_1_0_1a3c_00000000_00000000_00000000_00000000
4_2_0_fa35_00000000_00000000_00000000_00000000
// second en dropped
5_1_2_0b40_13579bdf_2468ace0_fedcba98_76543210
5_1_0_0b40_00000000_00000000_00000000_00000000
5_2_2_0c50_aaaa5555_5555aaaa_0000ffff_ffff0000
5_2_0_0c50_00000000_00000000_00000000_00000000
// mixed traffic
6_3_1_0d00_89abcdef_01234567_fedcba98_76543210
6_1_0_0d10_00000000_00000000_00000000_00000000
6_2_0_0cf0_00000000_00000000_00000000_00000000
6_1_1_0e20_5a5a5a5a_a5a5a5a5_12121212_34343434
6_2_1_0e30_c0ffee00_00c0ffee_babe0000_0000babe
6_3_0_0e20_00000000_00000000_00000000_00000000
6_2_1_0120_77777777_66666666_55555555_44444444
6_1_0_5128_00000000_00000000_00000000_00000000
6_3_1_0ff0_0f0f1e1e_2d2d3c3c_4b4b5a5a_69697878
6_3_0_0ff0_00000000_00000000_00000000_00000000
6_1_1_0340_31415926_53589793_23846264_33832795
6_2_0_0330_00000000_00000000_00000000_00000000
6_1_0_0a30_00000000_00000000_00000000_00000000

// File: verif/memory_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memory_subsystem_tb;

   import bus_pkg::*;

   localparam int MAX_VECTORS    = 64;
   localparam int SETTLE_CYCLES  = 16;
   localparam int CYCLES_PER_VEC = 64;

   localparam logic [3:0] OP_READ      = 4'h0;
   localparam logic [3:0] OP_WRITE_DUP = 4'h2;

   // tid, mask, op, address, line
   typedef logic [155:0] vec_t;

   logic   bus_clk;
   logic   rst;
   logic   ic_en;
   logic   ic_wr;
   addr_t  ic_a;
   line_t  ic_write_data;
   line_t  ic_read_data;
   logic   ic_r;
   logic   dc_en;
   logic   dc_wr;
   addr_t  dc_a;
   line_t  dc_write_data;
   line_t  dc_read_data;
   logic   dc_r;

   vec_t   vectors [MAX_VECTORS];
   int     num_vectors = 0;
   // expected memory contents, one line per index
   line_t  shadow [MEM_LINES];
   string  test_names [7] = '{"unused", "write_read", "cross_port", "same_cycle",
                              "alias", "backpressure", "random_traffic"};

   memory_subsystem u_dut (
      .bus_clk       (bus_clk),
      .rst           (rst),
      .ic_en         (ic_en),
      .ic_wr         (ic_wr),
      .ic_a          (ic_a),
      .ic_write_data (ic_write_data),
      .ic_read_data  (ic_read_data),
      .ic_r          (ic_r),
      .dc_en         (dc_en),
      .dc_wr         (dc_wr),
      .dc_a          (dc_a),
      .dc_write_data (dc_write_data),
      .dc_read_data  (dc_read_data),
      .dc_r          (dc_r)
   );

   initial begin
      bus_clk = 1'b0;
      forever begin
         #4 bus_clk = ~bus_clk;
      end
   end

   task automatic check_line(input string name, input line_t expected, input line_t actual);
      if (actual !== expected) begin
         $display("FAILED %s: expected %h actual %h", name, expected, actual);
         $display("FAIL: see errors above");
         $fatal(1, "read data mismatch");
      end
   endtask

   task automatic check_ready(input string name, input int expected, input int actual);
      if (actual != expected) begin
         $display("FAILED %s: expected %0d r pulses actual %0d", name, expected, actual);
         $display("FAIL: see errors above");
         $fatal(1, "r pulse count mismatch");
      end
   endtask

   function automatic int count_vectors();
      int n;
      n = 0;
      while (n < MAX_VECTORS && !$isunknown(vectors[n])) begin
         n++;
      end
      return n;
   endfunction

   task automatic drive_request(input logic [3:0] mask, input logic wr, input addr_t ia,
                                input line_t id, input addr_t da, input line_t dd);
      ic_en         = mask[0];
      ic_wr         = wr;
      ic_a          = ia;
      ic_write_data = id;
      dc_en         = mask[1];
      dc_wr         = wr;
      dc_a          = da;
      dc_write_data = dd;
   endtask

   task automatic drop_requests();
      ic_en = 1'b0;
      dc_en = 1'b0;
   endtask

   // one entry, dc takes the next line and the inverted data
   task automatic run_entry(input int idx, input vec_t v);
      logic [3:0] tid;
      logic [3:0] mask;
      logic [3:0] op;
      addr_t      addr;
      line_t      data;
      addr_t      dc_addr;
      string      name;
      int         ic_pulses;
      int         dc_pulses;
      int         cycles;
      int         quiet;
      tid       = v[155:152];
      mask      = v[151:148];
      op        = v[147:144];
      addr      = v[143:128];
      data      = v[127:0];
      dc_addr   = addr + 16'h0010;
      name      = $sformatf("%s[%0d]", (tid <= 6) ? test_names[tid] : "unknown", idx);
      ic_pulses = 0;
      dc_pulses = 0;
      cycles    = 0;
      quiet     = 0;
      drive_request(mask, op != OP_READ, addr, data, dc_addr, ~data);
      while (quiet < SETTLE_CYCLES) begin
         @(negedge bus_clk);
         cycles++;
         if (ic_r) begin
            ic_pulses++;
            if (op == OP_READ) begin
               check_line({name, " ic read"}, shadow[addr[11:4]], ic_read_data);
            end else begin
               shadow[addr[11:4]] = data;
            end
         end
         if (dc_r) begin
            dc_pulses++;
            if (op == OP_READ) begin
               check_line({name, " dc read"}, shadow[dc_addr[11:4]], dc_read_data);
            end else begin
               shadow[dc_addr[11:4]] = ~data;
            end
         end
         if (cycles == 1 || (op == OP_WRITE_DUP && cycles == 4)) begin
            drop_requests();
         end
         // port is mid-transfer here, so this request must be lost
         if (op == OP_WRITE_DUP && cycles == 3) begin
            drive_request(mask, 1'b1, addr, ~data, dc_addr, data);
         end
         if ((!mask[0] || ic_pulses > 0) && (!mask[1] || dc_pulses > 0)) begin
            quiet++;
         end
      end
      check_ready({name, " ic r"}, int'(mask[0]), ic_pulses);
      check_ready({name, " dc r"}, int'(mask[1]), dc_pulses);
   endtask

   initial begin
      wait (num_vectors > 0);
      repeat (num_vectors * CYCLES_PER_VEC) @(posedge bus_clk);
      $display("timeout: the requests did not complete within %0d cycles",
               num_vectors * CYCLES_PER_VEC);
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

   // bound checker counts its failed assertions
   initial begin
      wait (u_dut.u_bus_chk.fail_count != 0);
      $display("a bus protocol assertion failed");
      $display("FAIL: see errors above");
      $fatal(1, "assertion failure");
   end

   initial begin
      void'($urandom(32'h87c0));
      rst = 1'b1;
      drive_request(4'h0, 1'b0, '0, '0, '0, '0);
      $readmemh("verif/mem_vectors.txt", vectors);
      repeat (2) @(posedge bus_clk);
      @(negedge bus_clk);
      rst = 1'b0;
      if (count_vectors() == 0) begin
         $display("the vector file holds no request entries");
         $display("FAIL: see errors above");
         $fatal(1, "no vectors");
      end else begin
         num_vectors = count_vectors();
         for (int i = 0; i < num_vectors; i++) begin
            // idle gap, new request always starts on a falling edge
            repeat (($urandom % 4) + 1) @(negedge bus_clk);
            run_entry(i, vectors[i]);
         end
         $display("PASS: all tests");
         $finish;
      end
   end

endmodule

`default_nettype wire
